// File: src/console_pkg.sv
// Shared console geometry, character codes and bus structs; imported by every console module
package console_pkg;

  // Screen geometry
  localparam logic [7:0] COLS        = 8'd80;  // Characters per text line
  localparam int unsigned ROWS       = 34;
  localparam int unsigned FONT_HEIGHT = 8;     // Scan lines per text row

  localparam int unsigned ADDR_W = 12;
  localparam int unsigned CHAR_W = 8;
  localparam int unsigned TAB_W  = 3;

  // Buffer is exactly one screen, 2720 cells
  localparam logic [ADDR_W-1:0] SCREEN_SIZE = ADDR_W'(COLS * ROWS);

  // Character codes the decoder looks at
  localparam logic [CHAR_W-1:0] CH_HT    = 8'h09;
  localparam logic [CHAR_W-1:0] CH_LF    = 8'h0A;
  localparam logic [CHAR_W-1:0] CH_CR    = 8'h0D;
  localparam logic [CHAR_W-1:0] CH_SPACE = 8'h20;  // First printable code
  localparam logic [CHAR_W-1:0] CH_DEL   = 8'h7F;

  localparam logic [CHAR_W-1:0] BLANK = 8'h00;  // Empty cell

  typedef logic [CHAR_W-1:0] char_t;
  typedef logic [ADDR_W-1:0] addr_t;

  typedef enum logic [1:0] {
    CMD_PUT,      // Write glyph at cursor
    CMD_TAB,      // Run of blanks
    CMD_NEWLINE   // CR or LF
  } cmd_kind_t;

  // Decoder to writer
  typedef struct packed {
    logic      valid;
    cmd_kind_t kind;
    char_t     ch;
  } console_cmd_t;

  // Writer to character RAM
  typedef struct packed {
    logic  en;
    addr_t addr;
    char_t data;
  } ram_wr_t;

endpackage

// File: src/char_ram.sv
// Screen character RAM with one write port and a registered read port for the frame reader
`timescale 1ns/10ps

module char_ram (
  input  logic                  clk,
  input  console_pkg::ram_wr_t  i_wr,
  input  console_pkg::addr_t    i_rd_addr,
  output console_pkg::char_t    o_rd_data
);
  import console_pkg::*;

  // One byte per screen cell
  char_t mem [0:SCREEN_SIZE-1];

  always_ff @(posedge clk) begin
    if (i_wr.en) begin
      mem[i_wr.addr] <= i_wr.data;
    end
  end

  // Read data valid one cycle after the address
  always_ff @(posedge clk) begin
    o_rd_data <= mem[i_rd_addr];
  end

endmodule

// File: src/char_decoder.sv
// Combinational byte classifier that turns a qualified input strobe into a console command
`timescale 1ns/10ps

module char_decoder (
  input  logic                       i_char_stb,
  input  console_pkg::char_t         i_char,
  input  logic                       i_alt_func_en,
  input  logic                       i_wr_rdy,
  output console_pkg::console_cmd_t  o_cmd
);
  import console_pkg::*;

  cmd_kind_t kind;
  logic      known;   // Byte maps to some action

  // Control code table
  always_comb begin
    kind  = CMD_PUT;
    known = 1'b1;
    if (!i_alt_func_en) begin
      case (i_char)
        CH_CR, CH_LF: begin
          kind = CMD_NEWLINE;   // Both treated the same
        end
        CH_HT: begin
          kind = CMD_TAB;
        end
        default: begin
          // Printable range only, everything else dropped
          known = (i_char >= CH_SPACE) && (i_char < CH_DEL);
        end
      endcase
    end
  end

  // In alternate mode every byte is a glyph
  always_comb begin
    o_cmd.valid = i_char_stb && i_wr_rdy && known;  // Strobe lost when not ready
    o_cmd.kind  = kind;
    o_cmd.ch    = i_char;
  end

endmodule

// File: src/char_writer.sv
// Write FSM that owns the cursor and fills character cells for glyphs, tabs, newlines and clears
`timescale 1ns/10ps

module char_writer (
  input  logic                           clk,
  input  logic                           rst,
  input  console_pkg::console_cmd_t      i_cmd,
  input  logic [console_pkg::TAB_W-1:0]  i_tab_count,
  input  logic                           i_clear_screen_stb,
  input  logic                           i_reader_busy,
  output logic                           o_wr_rdy,
  output logic                           o_busy,
  output console_pkg::ram_wr_t           o_wr
);
  import console_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_PUT,
    S_TAB_FILL,
    S_LINE_FILL,
    S_NEXT_FILL,
    S_CLEAR
  } state_t;

  state_t           state;
  addr_t            cursor;
  addr_t            cursor_inc;
  addr_t            line_end;       // Last cell of the cursor's line
  addr_t            line_end_inc;
  addr_t            line_start;
  logic [TAB_W-1:0] tab_left;
  logic             clear_req;
  logic             at_line_end;
  logic             at_last_cell;
  logic             fill_en;

  // Cursor step with wrap at the end of the screen
  always_comb begin
    at_line_end  = (cursor == line_end);
    at_last_cell = (cursor == SCREEN_SIZE - 1'b1);
    cursor_inc   = at_last_cell ? '0 : cursor + 1'b1;
    line_end_inc = line_end;
    if (at_line_end) begin
      // Line end follows the cursor onto the next line
      line_end_inc = (line_end == SCREEN_SIZE - 1'b1) ? addr_t'(COLS - 1'b1)
                                                      : line_end + addr_t'(COLS);
    end
    line_start = line_end - addr_t'(COLS - 1'b1);
  end

  // States that write a blank at the cursor this cycle
  always_comb begin
    case (state)
      S_TAB_FILL:  fill_en = (tab_left != '0);
      S_LINE_FILL: fill_en = 1'b1;
      S_NEXT_FILL: fill_en = 1'b1;
      S_CLEAR:     fill_en = 1'b1;
      default:     fill_en = 1'b0;
    endcase
  end

  // A pending RAM write still counts as busy
  assign o_busy   = (state != S_IDLE) || o_wr.en;
  assign o_wr_rdy = !o_busy && !i_reader_busy && !clear_req;

  always_ff @(posedge clk) begin
    o_wr.en <= 1'b0;
    if (rst) begin
      state     <= S_CLEAR;   // Screen is wiped after reset
      cursor    <= '0;
      line_end  <= addr_t'(COLS - 1'b1);
      tab_left  <= '0;
      clear_req <= 1'b0;
    end else begin
      if (fill_en) begin
        o_wr.en   <= 1'b1;
        o_wr.addr <= cursor;
        o_wr.data <= BLANK;
      end

      case (state)
        S_IDLE: begin
          if (clear_req && !i_reader_busy) begin
            clear_req <= 1'b0;
            cursor    <= '0;
            line_end  <= addr_t'(COLS - 1'b1);
            state     <= S_CLEAR;
          end else if (i_cmd.valid) begin
            case (i_cmd.kind)
              CMD_PUT: begin
                o_wr.en   <= 1'b1;
                o_wr.addr <= cursor;
                o_wr.data <= i_cmd.ch;
                state     <= S_PUT;
              end
              CMD_TAB: begin
                tab_left <= i_tab_count;  // Count sampled at acceptance
                state    <= S_TAB_FILL;
              end
              default: begin
                state <= S_LINE_FILL;
              end
            endcase
          end
        end
        S_PUT: begin
          cursor   <= cursor_inc;
          line_end <= line_end_inc;
          state    <= S_IDLE;
        end
        S_TAB_FILL: begin
          if (tab_left != '0) begin
            cursor   <= cursor_inc;
            line_end <= line_end_inc;
            tab_left <= tab_left - 1'b1;
          end else begin
            state <= S_IDLE;
          end
        end
        S_LINE_FILL: begin
          cursor   <= cursor_inc;
          line_end <= line_end_inc;
          if (at_line_end) begin
            state <= S_NEXT_FILL;   // Now on the following line
          end
        end
        S_NEXT_FILL: begin
          if (at_line_end) begin
            cursor <= line_start;   // Park at start of the blanked line
            state  <= S_IDLE;
          end else begin
            cursor <= cursor_inc;
          end
        end
        S_CLEAR: begin
          cursor   <= cursor_inc;
          line_end <= line_end_inc;
          if (at_last_cell) begin
            state <= S_IDLE;        // Cursor has wrapped to 0
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase

      if (i_clear_screen_stb) begin
        clear_req <= 1'b1;
      end
    end
  end

endmodule

// File: src/frame_reader.sv
// Read FSM that streams the screen in raster order, repeating each text row per font scan line
`timescale 1ns/10ps

module frame_reader (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_read_frame_stb,
  input  logic                i_char_req_en,
  input  logic                i_writer_busy,
  output logic                o_busy,
  output console_pkg::addr_t  o_rd_addr,
  output logic                o_char_rdy
);
  import console_pkg::*;

  typedef enum logic [2:0] {
    R_IDLE,
    R_START,
    R_START_DLY,
    R_FETCH,
    R_FETCH_DLY
  } state_t;

  state_t                          state;
  logic [7:0]                      col;
  logic [$clog2(FONT_HEIGHT)-1:0]  font_row;
  addr_t                           row_base;   // First cell of the current text row
  addr_t                           next_base;
  logic                            last_col;
  logic                            last_pass;

  always_comb begin
    last_col  = (col == COLS - 1'b1);
    last_pass = (font_row == FONT_HEIGHT - 1);
    next_base = row_base + addr_t'(COLS);
  end

  assign o_busy = (state != R_IDLE);

  always_ff @(posedge clk) begin
    o_char_rdy <= 1'b0;
    if (rst) begin
      state     <= R_IDLE;
      col       <= '0;
      font_row  <= '0;
      row_base  <= '0;
      o_rd_addr <= '0;
    end else begin
      case (state)
        R_IDLE: begin
          font_row <= '0;
        end
        R_START: begin
          // Hold off until the writer has finished
          if (!i_writer_busy) begin
            col       <= '0;
            font_row  <= '0;
            row_base  <= '0;
            o_rd_addr <= '0;
            state     <= R_START_DLY;
          end
        end
        R_START_DLY: begin
          state <= R_FETCH;
        end
        R_FETCH: begin
          if (i_char_req_en) begin
            o_char_rdy <= 1'b1;   // Lines up with RAM read data
            state      <= R_FETCH_DLY;
            if (!last_col) begin
              col       <= col + 1'b1;
              o_rd_addr <= o_rd_addr + 1'b1;
            end else if (!last_pass) begin
              // Same text row again for the next scan line
              col       <= '0;
              font_row  <= font_row + 1'b1;
              o_rd_addr <= row_base;
            end else begin
              col       <= '0;
              font_row  <= '0;
              row_base  <= next_base;
              o_rd_addr <= (next_base == SCREEN_SIZE) ? '0 : next_base;
            end
          end
        end
        R_FETCH_DLY: begin
          state <= (row_base == SCREEN_SIZE) ? R_IDLE : R_FETCH;
        end
        default: begin
          state <= R_IDLE;
        end
      endcase

      if (i_read_frame_stb) begin
        state <= R_START;   // Also restarts a running frame
      end
    end
  end

endmodule

// File: src/character_buffer.sv
// Console character buffer top; bytes in on a strobe, screen out in raster order to the font renderer
`timescale 1ns/10ps

module character_buffer (
  input  logic                           clk,
  input  logic                           rst,

  input  logic                           i_char_stb,
  input  console_pkg::char_t             i_char,
  input  logic                           i_alt_func_en,
  input  logic [console_pkg::TAB_W-1:0]  i_tab_count,
  input  logic                           i_clear_screen_stb,
  output logic                           o_wr_char_rdy,

  input  logic                           i_read_frame_stb,
  input  logic                           i_char_req_en,
  output logic                           o_char_rdy,
  output console_pkg::char_t             o_char
);
  import console_pkg::*;

  console_cmd_t cmd;
  ram_wr_t      ram_wr;
  addr_t        rd_addr;
  logic         writer_busy;
  logic         reader_busy;

  char_decoder u_decoder (
    .i_char_stb    (i_char_stb),
    .i_char        (i_char),
    .i_alt_func_en (i_alt_func_en),
    .i_wr_rdy      (o_wr_char_rdy),
    .o_cmd         (cmd)
  );

  char_writer u_writer (
    .clk                (clk),
    .rst                (rst),
    .i_cmd              (cmd),
    .i_tab_count        (i_tab_count),
    .i_clear_screen_stb (i_clear_screen_stb),
    .i_reader_busy      (reader_busy),
    .o_wr_rdy           (o_wr_char_rdy),
    .o_busy             (writer_busy),
    .o_wr               (ram_wr)
  );

  // Reader and writer lock each other out through the busy pair
  frame_reader u_reader (
    .clk              (clk),
    .rst              (rst),
    .i_read_frame_stb (i_read_frame_stb),
    .i_char_req_en    (i_char_req_en),
    .i_writer_busy    (writer_busy),
    .o_busy           (reader_busy),
    .o_rd_addr        (rd_addr),
    .o_char_rdy       (o_char_rdy)
  );

  char_ram u_ram (
    .clk       (clk),
    .i_wr      (ram_wr),
    .i_rd_addr (rd_addr),
    .o_rd_data (o_char)   // Valid with o_char_rdy
  );

endmodule

// File: verification/console_checker.sv
// Testbench checker that models the screen from accepted bytes and compares every streamed character
`timescale 1ns/10ps

module console_checker (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           i_char_stb,
  input  console_pkg::char_t             i_char,
  input  logic                           i_alt_func_en,
  input  logic [console_pkg::TAB_W-1:0]  i_tab_count,
  input  logic                           i_clear_screen_stb,
  input  logic                           i_wr_char_rdy,
  input  logic                           i_read_frame_stb,
  input  logic                           i_char_rdy,
  input  console_pkg::char_t             i_rd_char,     // DUT o_char
  input  logic                           i_frame_done,  // Pulsed by the testbench after a frame
  input  int                             i_test_num,
  output int                             o_pass_count,
  output int                             o_fail_count
);
  import console_pkg::*;

  localparam int unsigned CELLS        = SCREEN_SIZE;
  localparam int unsigned LINE_LEN     = COLS;
  localparam int unsigned FRAME_PULSES = CELLS * FONT_HEIGHT;
  localparam int unsigned MAX_PRINTS   = 8;  // Mismatch lines shown per test

  char_t       screen [0:CELLS-1];
  int unsigned cursor;
  int unsigned pulse_cnt;
  int unsigned test_errors;
  logic        frame_active;
  char_t       exp_char;
  int          rdy_low_left;  // Negative when no ready timing is expected
  logic        rdy_skip;      // Reader or clear may hold ready low

  function automatic void clear_model();
    int unsigned i;
    for (i = 0; i < CELLS; i++)
      screen[i] = BLANK;
    cursor = 0;
  endfunction

  // Write rules of the console for one accepted byte
  function automatic void apply_byte(input char_t ch, input logic alt, input int unsigned tab);
    int unsigned i;
    int unsigned line_last;
    int unsigned next_line;
    if (alt || (ch >= CH_SPACE && ch < CH_DEL)) begin
      screen[cursor] = ch;
      cursor = (cursor + 1) % CELLS;
    end else if (ch == CH_HT) begin
      for (i = 0; i < tab; i++) begin
        screen[cursor] = BLANK;
        cursor = (cursor + 1) % CELLS;
      end
    end else if (ch == CH_CR || ch == CH_LF) begin
      line_last = (cursor / LINE_LEN) * LINE_LEN + LINE_LEN - 1;
      next_line = (line_last + 1) % CELLS;  // Last line wraps to the first
      for (i = cursor; i <= line_last; i++)
        screen[i] = BLANK;
      for (i = next_line; i < next_line + LINE_LEN; i++)
        screen[i] = BLANK;
      cursor = next_line;
    end
  endfunction

  // Cycles of low ready after an accepted byte with -1 for a newline
  function automatic int ready_low_cycles(input char_t ch, input logic alt,
                                          input int unsigned tab);
    if (alt || (ch >= CH_SPACE && ch < CH_DEL))
      return 1;
    else if (ch == CH_HT)
      return tab + 1;
    else if (ch == CH_CR || ch == CH_LF)
      return -1;
    return 0;
  endfunction

  // Raster index to cell with each text row repeated per scan line
  function automatic char_t expected_char(input int unsigned idx);
    int unsigned row;
    row = idx / (LINE_LEN * FONT_HEIGHT);
    return screen[row * LINE_LEN + idx % LINE_LEN];
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      clear_model();  // DUT clears itself after reset
      pulse_cnt    = 0;
      test_errors  = 0;
      frame_active = 1'b0;
      rdy_low_left = -1;
      rdy_skip     = 1'b0;
      o_pass_count = 0;
      o_fail_count = 0;
    end else begin
      if (rdy_low_left > 0) begin
        if (i_wr_char_rdy !== 1'b0) begin
          $display("ERROR at %0t ns: o_wr_char_rdy expected 0, got %b",
                   $time, i_wr_char_rdy);
          test_errors++;
        end
        rdy_low_left--;
      end else if (rdy_low_left == 0) begin
        if (!rdy_skip && i_wr_char_rdy !== 1'b1) begin
          $display("ERROR at %0t ns: o_wr_char_rdy expected 1, got %b",
                   $time, i_wr_char_rdy);
          test_errors++;
        end
        rdy_low_left = -1;
      end
      if (i_clear_screen_stb)
        clear_model();
      if (i_char_stb && i_wr_char_rdy) begin
        apply_byte(i_char, i_alt_func_en, i_tab_count);
        rdy_low_left = ready_low_cycles(i_char, i_alt_func_en, i_tab_count);
        rdy_skip     = 1'b0;
      end
      if (i_clear_screen_stb || i_read_frame_stb)
        rdy_skip = 1'b1;
      if (i_read_frame_stb) begin
        frame_active = 1'b1;
        pulse_cnt    = 0;
      end
      if (i_char_rdy) begin
        if (!frame_active) begin
          $display("Test %0d: o_char_rdy pulsed at %0t ns with no frame requested",
                   i_test_num, $time);
          test_errors++;
        end else if (pulse_cnt < FRAME_PULSES) begin
          exp_char = expected_char(pulse_cnt);
          if (i_rd_char !== exp_char) begin
            if (test_errors < MAX_PRINTS)
              $display("ERROR at %0t ns: o_char expected 0x%02h, got 0x%02h (pulse %0d)",
                       $time, exp_char, i_rd_char, pulse_cnt);
            test_errors++;
          end
        end
        pulse_cnt++;
      end
      if (i_frame_done) begin
        if (pulse_cnt != FRAME_PULSES) begin
          $display("Test %0d: frame delivered %0d characters instead of %0d",
                   i_test_num, pulse_cnt, FRAME_PULSES);
          test_errors++;
        end
        if (test_errors == 0) begin
          o_pass_count++;
          $display("Test %0d: PASS", i_test_num);
        end else begin
          o_fail_count++;
          $display("Test %0d: FAIL with %0d errors", i_test_num, test_errors);
        end
        frame_active = 1'b0;
        pulse_cnt    = 0;
        test_errors  = 0;
      end
    end
  end

endmodule

// File: verification/tb_character_buffer.sv
// Testbench top for the console buffer; writes text, reads frames and prints the overall result
`timescale 1ns/10ps

module tb_character_buffer;
  import console_pkg::*;

  localparam int unsigned FRAME_PULSES = int'(SCREEN_SIZE) * FONT_HEIGHT;
  localparam int unsigned MAX_CYCLES   = 6 * (FRAME_PULSES * 4 + 100);  // Six frames with slack

  logic             clk = 1'b0;
  logic             rst;
  logic             i_char_stb;
  char_t            i_char;
  logic             i_alt_func_en;
  logic [TAB_W-1:0] i_tab_count;
  logic             i_clear_screen_stb;
  logic             i_read_frame_stb;
  logic             i_char_req_en;
  logic             o_wr_char_rdy;
  logic             o_char_rdy;
  char_t            o_char;
  logic             frame_done;
  int               test_num;
  int               pass_count;
  int               fail_count;
  int unsigned      cycle_cnt = 0;
  int               seed;

  always #5 clk = ~clk;

  character_buffer i_dut (
    .clk(clk), .rst(rst),
    .i_char_stb(i_char_stb), .i_char(i_char),
    .i_alt_func_en(i_alt_func_en), .i_tab_count(i_tab_count),
    .i_clear_screen_stb(i_clear_screen_stb), .o_wr_char_rdy(o_wr_char_rdy),
    .i_read_frame_stb(i_read_frame_stb), .i_char_req_en(i_char_req_en),
    .o_char_rdy(o_char_rdy), .o_char(o_char)
  );

  console_checker u_checker (
    .clk(clk), .rst(rst),
    .i_char_stb(i_char_stb), .i_char(i_char),
    .i_alt_func_en(i_alt_func_en), .i_tab_count(i_tab_count),
    .i_clear_screen_stb(i_clear_screen_stb), .i_wr_char_rdy(o_wr_char_rdy),
    .i_read_frame_stb(i_read_frame_stb), .i_char_rdy(o_char_rdy), .i_rd_char(o_char),
    .i_frame_done(frame_done), .i_test_num(test_num),
    .o_pass_count(pass_count), .o_fail_count(fail_count)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("Timeout: no result after %0d cycles, DUT stopped responding", cycle_cnt);
      $display("Test failed");
      $finish;
    end
  end

  // All waits end at the drive point 1 ns after a rising edge
  task automatic wait_ready();
    while (!o_wr_char_rdy) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic put_char(input char_t ch);
    wait_ready();
    i_char_stb = 1'b1;
    i_char     = ch;
    @(posedge clk);
    #1;
    i_char_stb = 1'b0;
  endtask

  // Printable codes cycling from first through 0x7E
  task automatic put_pattern(input int unsigned count, input char_t first);
    int unsigned i;
    for (i = 0; i < count; i++)
      put_char(char_t'(32 + (first - 32 + i) % 95));
  endtask

  task automatic clear_screen();
    i_clear_screen_stb = 1'b1;
    @(posedge clk);
    #1;
    i_clear_screen_stb = 1'b0;
    wait_ready();
  endtask

  // Writer ready stays low while the reader is busy and its return marks the frame end
  task automatic read_frame(input int num, input int unsigned gap_pct);
    int unsigned r;
    test_num         = num;
    i_read_frame_stb = 1'b1;
    @(posedge clk);
    #1;
    i_read_frame_stb = 1'b0;
    while (!o_wr_char_rdy) begin
      r = $random(seed);
      i_char_req_en = (r % 100) >= gap_pct;
      @(posedge clk);
      #1;
    end
    i_char_req_en = 1'b0;
    frame_done    = 1'b1;
    @(posedge clk);
    #1;
    frame_done    = 1'b0;
  endtask

  initial begin
    int k;
    seed               = 32'hf890;
    rst                = 1'b1;
    i_char_stb         = 1'b0;
    i_char             = '0;
    i_alt_func_en      = 1'b0;
    i_tab_count        = '0;
    i_clear_screen_stb = 1'b0;
    i_read_frame_stb   = 1'b0;
    i_char_req_en      = 1'b0;
    frame_done         = 1'b0;
    test_num           = 1;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    wait_ready();                 // Automatic clear
    read_frame(1, 25);

    put_pattern(114, "A");        // Runs into row 1
    read_frame(2, 25);

    put_pattern(4, "L");
    put_char(CH_CR);
    put_char(CH_LF);
    put_pattern(4, "N");
    put_char(CH_LF);
    put_char("X");                // Row 4
    read_frame(3, 25);

    for (k = 0; k < 4; k++) begin
      i_tab_count = TAB_W'($random(seed));
      put_char(CH_HT);
      put_char(char_t'("T" + k));
    end
    put_char(8'h01);              // Ignored without alternate mode
    put_char(8'h08);
    put_char(8'h1B);
    put_char(CH_DEL);
    put_char(8'hFF);
    i_alt_func_en = 1'b1;
    put_char(8'h01);
    put_char(CH_CR);
    put_char(CH_HT);
    put_char(CH_DEL);
    put_char(8'hFF);
    i_alt_func_en = 1'b0;
    put_char(CH_LF);              // Cursor at row 5
    read_frame(4, 25);

    repeat (28) put_char(CH_LF);  // Down to the last row
    put_pattern(80, "a");         // Fills row 33 and wraps to cell 0
    put_pattern(4, "W");
    put_char(CH_CR);              // Blanks old text on rows 0 and 1
    put_pattern(3, "E");
    read_frame(5, 60);

    clear_screen();
    read_frame(6, 25);

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && pass_count == 6) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: sim.f
src/console_pkg.sv
src/char_ram.sv
src/char_decoder.sv
src/char_writer.sv
src/frame_reader.sv
src/character_buffer.sv
verification/console_checker.sv
verification/tb_character_buffer.sv
